// File: Makefile
# Verilator flow for the core_ctrl testbench

VERILATOR  ?= verilator
TOP        ?= core_ctrl_tb
FILELIST   ?= core_ctrl.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT  ?= SIMULATION PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is kept in a shell variable and searched for the pass line
run: build
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_TEXT)"; then \
	  echo "make run: pass line found"; \
	else \
	  echo "make run: pass line missing"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: common/core_ctrl_pkg.sv
package core_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Fetch address width
  localparam int unsigned XLEN = 32;

  //////////////////////////////////////////////////////////////////////
  // Controller types
  //////////////////////////////////////////////////////////////////////

  // Controller FSM states
  typedef enum logic [2:0] {
    RESET        = 3'd0,
    FIRST_FETCH  = 3'd1,
    FUNCTIONAL   = 3'd2,
    SLEEP        = 3'd3,
    DBG_FLUSH    = 3'd4,
    DBG_TAKEN_ID = 3'd5,
    DBG_TAKEN_IF = 3'd6,
    DBG_HALTED   = 3'd7
  } ctrl_state_e;

  // Source selected for the next PC value
  typedef enum logic [2:0] {
    PC_HOLD   = 3'd0,
    PC_BOOT   = 3'd1,
    PC_INCR   = 3'd2,
    PC_BRANCH = 3'd3,
    PC_HALT   = 3'd4,
    PC_DPC    = 3'd5
  } pc_src_e;

  // Debug entry cause, dcsr.cause encoding
  typedef enum logic [2:0] {
    CAUSE_NONE    = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } dbg_cause_e;

endpackage

// File: controller/ctrl_fsm.sv
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  logic                       instr_valid_i,
  input  logic                       id_ready_i,
  input  logic                       branch_taken_i,
  input  logic                       ebreak_i,
  input  logic                       wfi_i,
  input  logic                       debug_req_i,
  input  logic                       step_i,
  input  logic                       wakeup_i,
  input  logic                       resume_i,
  input  logic                       debug_mode_q_i,
  output core_ctrl_pkg::ctrl_state_e ctrl_fsm_cs_o,
  output core_ctrl_pkg::pc_src_e     pc_src_o,
  output logic                       dpc_capture_o,
  output logic                       dpc_use_next_o,
  output core_ctrl_pkg::dbg_cause_e  enter_cause_o,
  output logic                       resume_o,
  output logic                       first_done_o,
  output logic                       fetch_en_o,
  output logic                       retire_o,
  output logic                       sleeping_o
);

  core_ctrl_pkg::ctrl_state_e ctrl_fsm_cs;
  core_ctrl_pkg::ctrl_state_e ctrl_fsm_ns;

  // Flush was entered for a single step, picks the taken state
  logic step_entry_q;

  // Debug entry requests, ignored while already in debug mode
  logic dbg_req_valid;
  logic ebreak_valid;
  logic step_valid;
  logic retire;

  //////////////////////////////////////////////////////////////////////
  // Entry conditions
  //////////////////////////////////////////////////////////////////////

  assign dbg_req_valid = debug_req_i && !debug_mode_q_i;
  assign ebreak_valid  = ebreak_i && instr_valid_i && !debug_mode_q_i;
  assign step_valid    = step_i && !debug_mode_q_i;

  // Instruction leaves decode, halt and ebreak take precedence
  assign retire = (ctrl_fsm_cs == core_ctrl_pkg::FUNCTIONAL) &&
                  instr_valid_i && id_ready_i &&
                  !dbg_req_valid && !ebreak_i;

  //////////////////////////////////////////////////////////////////////
  // Next state and PC / dpc source selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_fsm_ns    = ctrl_fsm_cs;
    pc_src_o       = core_ctrl_pkg::PC_HOLD;
    dpc_capture_o  = 1'b0;
    dpc_use_next_o = 1'b0;
    enter_cause_o  = core_ctrl_pkg::CAUSE_NONE;
    resume_o       = 1'b0;
    fetch_en_o     = 1'b0;
    retire_o       = 1'b0;
    sleeping_o     = 1'b0;

    case (ctrl_fsm_cs)
      core_ctrl_pkg::RESET: begin
        // Load boot address, fetch starts next cycle
        pc_src_o    = core_ctrl_pkg::PC_BOOT;
        ctrl_fsm_ns = core_ctrl_pkg::FIRST_FETCH;
      end

      core_ctrl_pkg::FIRST_FETCH: begin
        fetch_en_o  = 1'b1;
        ctrl_fsm_ns = core_ctrl_pkg::FUNCTIONAL;
      end

      core_ctrl_pkg::FUNCTIONAL: begin
        fetch_en_o = 1'b1;
        if (dbg_req_valid) begin
          // Halt request, instruction in decode stays unretired
          dpc_capture_o = 1'b1;
          enter_cause_o = core_ctrl_pkg::CAUSE_HALTREQ;
          ctrl_fsm_ns   = core_ctrl_pkg::DBG_FLUSH;
        end else if (ebreak_valid) begin
          // dpc points at the ebreak itself
          dpc_capture_o = 1'b1;
          enter_cause_o = core_ctrl_pkg::CAUSE_EBREAK;
          ctrl_fsm_ns   = core_ctrl_pkg::DBG_FLUSH;
        end else if (retire) begin
          retire_o = 1'b1;
          pc_src_o = branch_taken_i ? core_ctrl_pkg::PC_BRANCH : core_ctrl_pkg::PC_INCR;
          if (wfi_i) begin
            ctrl_fsm_ns = core_ctrl_pkg::SLEEP;
          end else if (step_valid) begin
            // Step halts after the retire, dpc is the following address
            dpc_capture_o  = 1'b1;
            dpc_use_next_o = 1'b1;
            enter_cause_o  = core_ctrl_pkg::CAUSE_STEP;
            ctrl_fsm_ns    = core_ctrl_pkg::DBG_FLUSH;
          end
        end
      end

      core_ctrl_pkg::SLEEP: begin
        sleeping_o = 1'b1;
        // Halt request beats wakeup, PC already past the WFI
        if (dbg_req_valid) begin
          dpc_capture_o = 1'b1;
          enter_cause_o = core_ctrl_pkg::CAUSE_HALTREQ;
          ctrl_fsm_ns   = core_ctrl_pkg::DBG_TAKEN_IF;
        end else if (wakeup_i) begin
          ctrl_fsm_ns = core_ctrl_pkg::FUNCTIONAL;
        end
      end

      core_ctrl_pkg::DBG_FLUSH: begin
        // One cycle to drain the pipe
        ctrl_fsm_ns = step_entry_q ? core_ctrl_pkg::DBG_TAKEN_IF
                                   : core_ctrl_pkg::DBG_TAKEN_ID;
      end

      core_ctrl_pkg::DBG_TAKEN_ID,
      core_ctrl_pkg::DBG_TAKEN_IF: begin
        // Second capture strobe commits debug mode
        pc_src_o      = core_ctrl_pkg::PC_HALT;
        dpc_capture_o = 1'b1;
        ctrl_fsm_ns   = core_ctrl_pkg::DBG_HALTED;
      end

      core_ctrl_pkg::DBG_HALTED: begin
        if (resume_i && debug_mode_q_i) begin
          resume_o    = 1'b1;
          pc_src_o    = core_ctrl_pkg::PC_DPC;
          ctrl_fsm_ns = core_ctrl_pkg::FUNCTIONAL;
        end
      end

      default: begin
        ctrl_fsm_ns = core_ctrl_pkg::RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_fsm_cs  <= core_ctrl_pkg::RESET;
      step_entry_q <= 1'b0;
    end else begin
      ctrl_fsm_cs <= ctrl_fsm_ns;
      // Remember flush reason for the taken state choice
      if (ctrl_fsm_ns == core_ctrl_pkg::DBG_FLUSH) begin
        step_entry_q <= (enter_cause_o == core_ctrl_pkg::CAUSE_STEP);
      end
    end
  end

  // Boot sequence is over once FIRST_FETCH is left
  assign first_done_o = (ctrl_fsm_cs != core_ctrl_pkg::RESET) &&
                        (ctrl_fsm_cs != core_ctrl_pkg::FIRST_FETCH);

  assign ctrl_fsm_cs_o = ctrl_fsm_cs;

endmodule

// File: core_ctrl.f
common/core_ctrl_pkg.sv
logic/pc_sequencer.sv
logic/debug_status.sv
controller/ctrl_fsm.sv
logic/core_ctrl_top.sv
verif/ctrl_fsm_checker.sv
verif/core_ctrl_tb.sv

// File: logic/core_ctrl_top.sv
`timescale 1ns/1ps

module core_ctrl_top #(
  parameter logic [core_ctrl_pkg::XLEN-1:0] BOOT_ADDR    = 32'h0000_0080,
  parameter logic [core_ctrl_pkg::XLEN-1:0] DM_HALT_ADDR = 32'h1a11_0800
) (
  input  logic                           clk,
  input  logic                           arst_n_i,
  input  logic                           instr_valid_i,
  input  logic                           id_ready_i,
  input  logic                           branch_taken_i,
  input  logic [core_ctrl_pkg::XLEN-1:0] branch_target_i,
  input  logic                           ebreak_i,
  input  logic                           wfi_i,
  input  logic                           debug_req_i,
  input  logic                           step_i,
  input  logic                           wakeup_i,
  input  logic                           resume_i,
  output logic [core_ctrl_pkg::XLEN-1:0] pc_o,
  output logic                           fetch_en_o,
  output logic                           retire_o,
  output logic                           sleeping_o,
  output logic                           debug_havereset_o,
  output logic                           debug_running_o,
  output logic                           debug_halted_o,
  output logic [core_ctrl_pkg::XLEN-1:0] dpc_o,
  output core_ctrl_pkg::dbg_cause_e      cause_o
);

  //////////////////////////////////////////////////////////////////////
  // Internal wiring
  //////////////////////////////////////////////////////////////////////

  core_ctrl_pkg::pc_src_e         pc_src;
  core_ctrl_pkg::dbg_cause_e      enter_cause;
  logic [core_ctrl_pkg::XLEN-1:0] pc_next;
  logic                           dpc_capture;
  logic                           dpc_use_next;
  logic                           resume;
  logic                           first_done;
  logic                           debug_mode_q;

  // Sequencing and debug entry decisions
  ctrl_fsm i_ctrl_fsm (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .instr_valid_i  (instr_valid_i),
    .id_ready_i     (id_ready_i),
    .branch_taken_i (branch_taken_i),
    .ebreak_i       (ebreak_i),
    .wfi_i          (wfi_i),
    .debug_req_i    (debug_req_i),
    .step_i         (step_i),
    .wakeup_i       (wakeup_i),
    .resume_i       (resume_i),
    .debug_mode_q_i (debug_mode_q),
    .ctrl_fsm_cs_o  (),
    .pc_src_o       (pc_src),
    .dpc_capture_o  (dpc_capture),
    .dpc_use_next_o (dpc_use_next),
    .enter_cause_o  (enter_cause),
    .resume_o       (resume),
    .first_done_o   (first_done),
    .fetch_en_o     (fetch_en_o),
    .retire_o       (retire_o),
    .sleeping_o     (sleeping_o)
  );

  // Fetch address
  pc_sequencer #(
    .BOOT_ADDR    (BOOT_ADDR),
    .DM_HALT_ADDR (DM_HALT_ADDR)
  ) i_pc_sequencer (
    .clk             (clk),
    .arst_n_i        (arst_n_i),
    .pc_src_i        (pc_src),
    .branch_taken_i  (branch_taken_i),
    .branch_target_i (branch_target_i),
    .dpc_i           (dpc_o),
    .pc_o            (pc_o),
    .pc_next_o       (pc_next)
  );

  // Debug mode, dpc, cause and status outputs
  debug_status i_debug_status (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .dpc_capture_i     (dpc_capture),
    .dpc_use_next_i    (dpc_use_next),
    .enter_cause_i     (enter_cause),
    .pc_i              (pc_o),
    .pc_next_i         (pc_next),
    .resume_i          (resume),
    .first_done_i      (first_done),
    .debug_mode_q_o    (debug_mode_q),
    .dpc_o             (dpc_o),
    .cause_o           (cause_o),
    .debug_havereset_o (debug_havereset_o),
    .debug_running_o   (debug_running_o),
    .debug_halted_o    (debug_halted_o)
  );

endmodule

// File: logic/debug_status.sv
`timescale 1ns/1ps

module debug_status (
  input  logic                           clk,
  input  logic                           arst_n_i,
  input  logic                           dpc_capture_i,
  input  logic                           dpc_use_next_i,
  input  core_ctrl_pkg::dbg_cause_e      enter_cause_i,
  input  logic [core_ctrl_pkg::XLEN-1:0] pc_i,
  input  logic [core_ctrl_pkg::XLEN-1:0] pc_next_i,
  input  logic                           resume_i,
  input  logic                           first_done_i,
  output logic                           debug_mode_q_o,
  output logic [core_ctrl_pkg::XLEN-1:0] dpc_o,
  output core_ctrl_pkg::dbg_cause_e      cause_o,
  output logic                           debug_havereset_o,
  output logic                           debug_running_o,
  output logic                           debug_halted_o
);

  logic                           debug_mode_q;
  logic                           entry_pending_q;
  logic                           havereset_q;
  logic [core_ctrl_pkg::XLEN-1:0] dpc_q;
  core_ctrl_pkg::dbg_cause_e      cause_q;

  // First strobe of an entry loads dpc and cause
  logic capture_load;
  // Second strobe, in the taken state, sets debug mode
  logic capture_commit;

  assign capture_load   = dpc_capture_i && !entry_pending_q;
  assign capture_commit = dpc_capture_i && entry_pending_q;

  //////////////////////////////////////////////////////////////////////
  // Debug state flags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      debug_mode_q    <= 1'b0;
      entry_pending_q <= 1'b0;
      havereset_q     <= 1'b1;
      cause_q         <= core_ctrl_pkg::CAUSE_NONE;
    end else begin
      if (capture_load) begin
        entry_pending_q <= 1'b1;
        cause_q         <= enter_cause_i;
      end else if (capture_commit) begin
        entry_pending_q <= 1'b0;
        debug_mode_q    <= 1'b1;
      end
      if (resume_i) begin
        debug_mode_q <= 1'b0;
      end
      // Cleared for good once boot fetch is done
      if (first_done_i) begin
        havereset_q <= 1'b0;
      end
    end
  end

  // Saved PC, either the unretired or the following instruction
  always_ff @(posedge clk) begin
    if (capture_load) begin
      dpc_q <= dpc_use_next_i ? pc_next_i : pc_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Status outputs, one-hot by construction
  //////////////////////////////////////////////////////////////////////

  assign debug_halted_o    = debug_mode_q;
  assign debug_havereset_o = havereset_q && !debug_mode_q;
  assign debug_running_o   = !havereset_q && !debug_mode_q;

  assign debug_mode_q_o = debug_mode_q;
  assign dpc_o          = dpc_q;
  assign cause_o        = cause_q;

endmodule

// File: logic/pc_sequencer.sv
`timescale 1ns/1ps

module pc_sequencer #(
  parameter logic [core_ctrl_pkg::XLEN-1:0] BOOT_ADDR    = 32'h0000_0080,
  parameter logic [core_ctrl_pkg::XLEN-1:0] DM_HALT_ADDR = 32'h1a11_0800
) (
  input  logic                           clk,
  input  logic                           arst_n_i,
  input  core_ctrl_pkg::pc_src_e         pc_src_i,
  input  logic                           branch_taken_i,
  input  logic [core_ctrl_pkg::XLEN-1:0] branch_target_i,
  input  logic [core_ctrl_pkg::XLEN-1:0] dpc_i,
  output logic [core_ctrl_pkg::XLEN-1:0] pc_o,
  output logic [core_ctrl_pkg::XLEN-1:0] pc_next_o
);

  // Instruction size, no compressed support
  localparam logic [core_ctrl_pkg::XLEN-1:0] INSTR_BYTES = 4;

  logic [core_ctrl_pkg::XLEN-1:0] pc_q;
  logic [core_ctrl_pkg::XLEN-1:0] pc_d;
  logic [core_ctrl_pkg::XLEN-1:0] pc_seq;

  //////////////////////////////////////////////////////////////////////
  // Next address
  //////////////////////////////////////////////////////////////////////

  assign pc_seq = pc_q + INSTR_BYTES;

  // Address of the instruction after the one in decode
  assign pc_next_o = branch_taken_i ? branch_target_i : pc_seq;

  always_comb begin
    case (pc_src_i)
      core_ctrl_pkg::PC_BOOT:   pc_d = BOOT_ADDR;
      core_ctrl_pkg::PC_INCR:   pc_d = pc_seq;
      core_ctrl_pkg::PC_BRANCH: pc_d = branch_target_i;
      core_ctrl_pkg::PC_HALT:   pc_d = DM_HALT_ADDR;
      core_ctrl_pkg::PC_DPC:    pc_d = dpc_i;
      default:                  pc_d = pc_q;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // PC register
  //////////////////////////////////////////////////////////////////////

  // Comes out of reset on the boot address
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= BOOT_ADDR;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

// File: verif/core_ctrl_tb.sv
`timescale 1ns/1ps

module core_ctrl_tb;

  localparam logic [core_ctrl_pkg::XLEN-1:0] BOOT_ADDR    = 32'h0000_0100;
  localparam logic [core_ctrl_pkg::XLEN-1:0] DM_HALT_ADDR = 32'h0000_0800;
  localparam int unsigned SEED          = 32'h64fd_5c78;
  localparam int unsigned RANDOM_CYCLES = 4000;
  // Longest expected wait is halt entry, three cycles
  localparam int unsigned WAIT_LIMIT    = 20;

  logic                           clk;
  logic                           arst_n_i;
  logic                           instr_valid_i;
  logic                           id_ready_i;
  logic                           branch_taken_i;
  logic [core_ctrl_pkg::XLEN-1:0] branch_target_i;
  logic                           ebreak_i;
  logic                           wfi_i;
  logic                           debug_req_i;
  logic                           step_i;
  logic                           wakeup_i;
  logic                           resume_i;
  logic [core_ctrl_pkg::XLEN-1:0] pc_o;
  logic                           fetch_en_o;
  logic                           retire_o;
  logic                           sleeping_o;
  logic                           debug_havereset_o;
  logic                           debug_running_o;
  logic                           debug_halted_o;
  logic [core_ctrl_pkg::XLEN-1:0] dpc_o;
  core_ctrl_pkg::dbg_cause_e      cause_o;

  // Reference model state
  core_ctrl_pkg::ctrl_state_e     m_state;
  core_ctrl_pkg::dbg_cause_e      m_cause;
  logic [core_ctrl_pkg::XLEN-1:0] m_pc;
  logic [core_ctrl_pkg::XLEN-1:0] m_dpc;
  logic                           m_dpc_valid;
  logic                           m_debug;
  logic                           m_havereset;
  logic                           m_step_entry;
  int unsigned                    n_retire;
  int unsigned                    n_halt;
  int unsigned                    n_step;
  int unsigned                    n_sleep;
  logic [core_ctrl_pkg::XLEN-1:0] addr_seen;

  core_ctrl_top #(
    .BOOT_ADDR    (BOOT_ADDR),
    .DM_HALT_ADDR (DM_HALT_ADDR)
  ) i_dut (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .branch_taken_i    (branch_taken_i),
    .branch_target_i   (branch_target_i),
    .ebreak_i          (ebreak_i),
    .wfi_i             (wfi_i),
    .debug_req_i       (debug_req_i),
    .step_i            (step_i),
    .wakeup_i          (wakeup_i),
    .resume_i          (resume_i),
    .pc_o              (pc_o),
    .fetch_en_o        (fetch_en_o),
    .retire_o          (retire_o),
    .sleeping_o        (sleeping_o),
    .debug_havereset_o (debug_havereset_o),
    .debug_running_o   (debug_running_o),
    .debug_halted_o    (debug_halted_o),
    .dpc_o             (dpc_o),
    .cause_o           (cause_o)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_addr(input string what, input logic [core_ctrl_pkg::XLEN-1:0] got,
                            input logic [core_ctrl_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      $display("** Error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic check_cause(input string what, input core_ctrl_pkg::dbg_cause_e got,
                             input core_ctrl_pkg::dbg_cause_e exp);
    if (got !== exp) begin
      $display("** Error @ %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
      $display("SIMULATION FAILED");
      $fatal(1, "cause mismatch");
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Cycle model
  //////////////////////////////////////////////////////////////////////

  // Retire needs a valid, ready instruction and no halt or ebreak
  function automatic logic expect_retire();
    return (m_state == core_ctrl_pkg::FUNCTIONAL) && instr_valid_i && id_ready_i &&
           !debug_req_i && !ebreak_i;
  endfunction

  task automatic enter_debug(input logic [core_ctrl_pkg::XLEN-1:0] addr,
                             input core_ctrl_pkg::dbg_cause_e cause,
                             input core_ctrl_pkg::ctrl_state_e next_state);
    m_dpc        = addr;
    m_dpc_valid  = 1'b1;
    m_cause      = cause;
    m_step_entry = (cause == core_ctrl_pkg::CAUSE_STEP);
    m_state      = next_state;
  endtask

  // Advance the model by one rising edge with the inputs of this cycle
  task automatic update_model();
    logic [core_ctrl_pkg::XLEN-1:0] next_addr;
    next_addr = branch_taken_i ? branch_target_i : m_pc + 32'd4;
    // Any state past the first fetch clears havereset
    if (m_state != core_ctrl_pkg::RESET && m_state != core_ctrl_pkg::FIRST_FETCH) begin
      m_havereset = 1'b0;
    end
    case (m_state)
      core_ctrl_pkg::RESET: begin
        m_pc    = BOOT_ADDR;
        m_state = core_ctrl_pkg::FIRST_FETCH;
      end
      core_ctrl_pkg::FIRST_FETCH: m_state = core_ctrl_pkg::FUNCTIONAL;
      core_ctrl_pkg::FUNCTIONAL: begin
        if (debug_req_i) begin
          enter_debug(m_pc, core_ctrl_pkg::CAUSE_HALTREQ, core_ctrl_pkg::DBG_FLUSH);
        end else if (ebreak_i && instr_valid_i) begin
          enter_debug(m_pc, core_ctrl_pkg::CAUSE_EBREAK, core_ctrl_pkg::DBG_FLUSH);
        end else if (expect_retire()) begin
          n_retire++;
          m_pc = next_addr;
          if (wfi_i) begin
            n_sleep++;
            m_state = core_ctrl_pkg::SLEEP;
          end else if (step_i) begin
            enter_debug(next_addr, core_ctrl_pkg::CAUSE_STEP, core_ctrl_pkg::DBG_FLUSH);
          end
        end
      end
      core_ctrl_pkg::SLEEP: begin
        if (debug_req_i) begin
          enter_debug(m_pc, core_ctrl_pkg::CAUSE_HALTREQ, core_ctrl_pkg::DBG_TAKEN_IF);
        end else if (wakeup_i) begin
          m_state = core_ctrl_pkg::FUNCTIONAL;
        end
      end
      core_ctrl_pkg::DBG_FLUSH: begin
        m_state = m_step_entry ? core_ctrl_pkg::DBG_TAKEN_IF : core_ctrl_pkg::DBG_TAKEN_ID;
      end
      core_ctrl_pkg::DBG_TAKEN_ID, core_ctrl_pkg::DBG_TAKEN_IF: begin
        n_halt++;
        if (m_cause == core_ctrl_pkg::CAUSE_STEP) n_step++;
        m_pc    = DM_HALT_ADDR;
        m_debug = 1'b1;
        m_state = core_ctrl_pkg::DBG_HALTED;
      end
      default: begin
        if (resume_i) begin
          m_pc    = m_dpc;
          m_debug = 1'b0;
          m_state = core_ctrl_pkg::FUNCTIONAL;
        end
      end
    endcase
  endtask

  task automatic compare_outputs();
    check_addr("pc_o", pc_o, m_pc);
    if (m_dpc_valid) check_addr("dpc_o", dpc_o, m_dpc);
    check_cause("cause_o", cause_o, m_cause);
    check_flag("fetch_en_o", fetch_en_o,
               m_state == core_ctrl_pkg::FIRST_FETCH || m_state == core_ctrl_pkg::FUNCTIONAL);
    check_flag("retire_o", retire_o, expect_retire());
    check_flag("sleeping_o", sleeping_o, m_state == core_ctrl_pkg::SLEEP);
    check_flag("debug_halted_o", debug_halted_o, m_debug);
    check_flag("debug_havereset_o", debug_havereset_o, m_havereset && !m_debug);
    check_flag("debug_running_o", debug_running_o, !m_havereset && !m_debug);
    check_flag("status one-hot",
               $onehot({debug_havereset_o, debug_running_o, debug_halted_o}), 1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Model steps on the rising edge, outputs compared mid-cycle
  task automatic run_cycle();
    @(posedge clk);
    update_model();
    @(negedge clk);
    compare_outputs();
  endtask

  task automatic idle_inputs();
    instr_valid_i   = 1'b0;
    id_ready_i      = 1'b0;
    branch_taken_i  = 1'b0;
    branch_target_i = '0;
    ebreak_i        = 1'b0;
    wfi_i           = 1'b0;
    debug_req_i     = 1'b0;
    step_i          = 1'b0;
    wakeup_i        = 1'b0;
    resume_i        = 1'b0;
  endtask

  // Rare halts, steps and WFIs, resume only while halted
  task automatic randomize_inputs();
    instr_valid_i   = ($urandom % 4) != 0;
    id_ready_i      = ($urandom % 4) != 0;
    branch_taken_i  = ($urandom % 5) == 0;
    branch_target_i = $urandom & 32'hffff_fffc;
    ebreak_i        = ($urandom % 30) == 0;
    wfi_i           = ($urandom % 25) == 0;
    debug_req_i     = ($urandom % 40) == 0;
    step_i          = ($urandom % 30) == 0;
    wakeup_i        = ($urandom % 6) == 0;
    resume_i        = debug_halted_o && (($urandom % 3) == 0);
  endtask

  task automatic wait_halted(input string why);
    int unsigned count;
    count = 0;
    while (!debug_halted_o && count < WAIT_LIMIT) begin
      run_cycle();
      count++;
    end
    if (!debug_halted_o) begin
      $display("Core never halted after %s within %0d cycles", why, WAIT_LIMIT);
      $display("SIMULATION FAILED");
      $fatal(1, "halt wait timed out");
    end
  endtask

  task automatic wait_running(input string why);
    int unsigned count;
    count = 0;
    while (!debug_running_o && count < WAIT_LIMIT) begin
      run_cycle();
      count++;
    end
    if (!debug_running_o) begin
      $display("Core never reported running after %s within %0d cycles", why, WAIT_LIMIT);
      $display("SIMULATION FAILED");
      $fatal(1, "running wait timed out");
    end
  endtask

  // Running and pc equal to dpc one cycle after the pulse
  task automatic resume_core();
    idle_inputs();
    resume_i = 1'b1;
    run_cycle();
    resume_i = 1'b0;
    check_flag("debug_running_o after resume", debug_running_o, 1'b1);
    check_addr("pc_o after resume", pc_o, m_dpc);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    clk      = 1'b0;
    arst_n_i = 1'b0;
    idle_inputs();
    m_state      = core_ctrl_pkg::RESET;
    m_cause      = core_ctrl_pkg::CAUSE_NONE;
    m_pc         = BOOT_ADDR;
    m_dpc        = '0;
    m_dpc_valid  = 1'b0;
    m_debug      = 1'b0;
    m_havereset  = 1'b1;
    m_step_entry = 1'b0;
    repeat (2) @(negedge clk);
    compare_outputs();
    arst_n_i = 1'b1;
    run_cycle();
    check_addr("pc_o in first fetch", pc_o, BOOT_ADDR);
    wait_running("reset");

    // Back-pressure holds the PC, then a taken branch
    addr_seen     = pc_o;
    instr_valid_i = 1'b1;
    run_cycle();
    check_addr("pc_o under back-pressure", pc_o, addr_seen);
    id_ready_i      = 1'b1;
    branch_taken_i  = 1'b1;
    branch_target_i = 32'h0000_0200;
    run_cycle();
    check_addr("pc_o after branch", pc_o, 32'h0000_0200);

    // Halt request reaches halted on the third cycle
    idle_inputs();
    addr_seen   = pc_o;
    debug_req_i = 1'b1;
    run_cycle();
    debug_req_i = 1'b0;
    run_cycle();
    check_flag("debug_halted_o two cycles after request", debug_halted_o, 1'b0);
    run_cycle();
    check_flag("debug_halted_o three cycles after request", debug_halted_o, 1'b1);
    check_addr("pc_o in halt", pc_o, DM_HALT_ADDR);
    check_addr("dpc_o for halt request", dpc_o, addr_seen);
    check_cause("cause_o for halt request", cause_o, core_ctrl_pkg::CAUSE_HALTREQ);
    resume_core();

    // Ebreak saves its own address
    addr_seen     = pc_o;
    instr_valid_i = 1'b1;
    ebreak_i      = 1'b1;
    run_cycle();
    idle_inputs();
    wait_halted("ebreak");
    check_addr("dpc_o for ebreak", dpc_o, addr_seen);
    check_cause("cause_o for ebreak", cause_o, core_ctrl_pkg::CAUSE_EBREAK);
    resume_core();

    // Single step halts after one retire
    addr_seen     = pc_o;
    instr_valid_i = 1'b1;
    id_ready_i    = 1'b1;
    step_i        = 1'b1;
    run_cycle();
    idle_inputs();
    wait_halted("single step");
    check_addr("dpc_o for step", dpc_o, addr_seen + 32'd4);
    check_cause("cause_o for step", cause_o, core_ctrl_pkg::CAUSE_STEP);
    resume_core();

    // WFI sleeps until wakeup
    instr_valid_i = 1'b1;
    id_ready_i    = 1'b1;
    wfi_i         = 1'b1;
    run_cycle();
    check_flag("sleeping_o after WFI", sleeping_o, 1'b1);
    idle_inputs();
    wakeup_i = 1'b1;
    run_cycle();
    check_flag("fetch_en_o after wakeup", fetch_en_o, 1'b1);

    // Halt request during sleep keeps the address after the WFI
    instr_valid_i = 1'b1;
    id_ready_i    = 1'b1;
    wfi_i         = 1'b1;
    run_cycle();
    addr_seen = pc_o;
    idle_inputs();
    debug_req_i = 1'b1;
    run_cycle();
    debug_req_i = 1'b0;
    wait_halted("halt request in sleep");
    check_addr("dpc_o for halt in sleep", dpc_o, addr_seen);
    resume_core();

    // Random phase
    n_retire = 0;
    n_halt   = 0;
    n_step   = 0;
    n_sleep  = 0;
    for (int unsigned cyc = 0; cyc < RANDOM_CYCLES; cyc++) begin
      randomize_inputs();
      run_cycle();
    end

    if (n_halt > 0 && n_step > 0 && n_sleep > 0) begin
      $display("Random phase: %0d retires, %0d halts, %0d steps, %0d sleeps",
               n_retire, n_halt, n_step, n_sleep);
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("Random phase never reached a halt, a step and a sleep");
      $display("SIMULATION FAILED");
      $fatal(1, "random stimulus too weak");
    end
  end

endmodule

// File: verif/ctrl_fsm_checker.sv
`timescale 1ns/1ps

module ctrl_fsm_checker (
  input logic                       clk,
  input logic                       arst_n_i,
  input core_ctrl_pkg::ctrl_state_e state_i,
  input logic                       step_i,
  input logic                       debug_mode_i,
  input logic                       retire_i,
  input logic                       fetch_en_i
);

  //////////////////////////////////////////////////////////////////////
  // Debug entry sequencing
  //////////////////////////////////////////////////////////////////////

  // Flush drains the pipe in a single cycle
  a_flush_one_cycle: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (state_i == core_ctrl_pkg::DBG_FLUSH) |=> (state_i != core_ctrl_pkg::DBG_FLUSH)
  ) else $error("DBG_FLUSH held for more than one cycle");

  // Taken in IF only for a step or a halt out of sleep
  // step_i is looked at in the cycle that entered the flush
  a_taken_if_source: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (state_i == core_ctrl_pkg::DBG_TAKEN_IF) |->
      (($past(state_i) == core_ctrl_pkg::SLEEP) ||
       (($past(state_i) == core_ctrl_pkg::DBG_FLUSH) && $past(step_i, 2)))
  ) else $error("DBG_TAKEN_IF entered without a step or a sleep halt");

  //////////////////////////////////////////////////////////////////////
  // Control outputs
  //////////////////////////////////////////////////////////////////////

  a_no_retire_in_debug: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    debug_mode_i |-> !retire_i
  ) else $error("Instruction retired in debug mode");

  a_no_fetch_in_sleep: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    (state_i == core_ctrl_pkg::SLEEP) |-> !fetch_en_i
  ) else $error("Fetch enabled while sleeping");

endmodule

bind ctrl_fsm ctrl_fsm_checker i_ctrl_fsm_checker (
  .clk          (clk),
  .arst_n_i     (arst_n_i),
  .state_i      (ctrl_fsm_cs_o),
  .step_i       (step_i),
  .debug_mode_i (debug_mode_q_i),
  .retire_i     (retire_o),
  .fetch_en_i   (fetch_en_o)
);
